/* verilog/miner_pkg.sv */
/*
 * Shared types and constants of the miner. Words are numbered from bit 0 upward,
 * so word 0 of a hash state is register a and word 7 is h. golden_bits may be
 * set anywhere from 1 to 32.
 */
`default_nettype none

package miner_pkg;

	typedef logic [31:0] word_t;

	// index 0 holds a, index 7 holds h
	typedef word_t [7:0] hash_state_t;

	typedef struct packed {
		hash_state_t midstate;
		logic [95:0] data;
	} work_t;

	localparam int num_rounds = 64;
	localparam int golden_bits = 8;
	localparam int work_bytes = 44;
	localparam int result_bytes = 12;

	// H0 sits in the low word
	localparam hash_state_t sha_iv = {
		32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
		32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
	};

	localparam word_t round_k [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// words 4 to 15 of the first block, the message being 640 bits long
	localparam word_t pad_first [0:11] = '{
		32'h80000000, 32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000, 32'd640
	};

	// words 8 to 15 of the second block, which hashes a 256-bit digest
	localparam word_t pad_second [0:7] = '{
		32'h80000000, 32'h00000000, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000000, 32'h00000000, 32'd256
	};

endpackage

`default_nettype wire

/* verilog/sha_round_if.sv */
/*
 * Control link between the miner FSM and the round datapath.
 * round is driven by the round counter and only read by the datapath.
 */
`timescale 1ns/10ps
`default_nettype none

interface sha_round_if
	import miner_pkg::*;
();

	// one-cycle pulse that starts a compression pass
	logic        load_state;
	// low for the block with the nonce, high for the hash of its digest
	logic        second_pass;
	logic        step;
	logic [5:0]  round;
	hash_state_t digest;

	modport ctrl (
		output load_state,
		output second_pass,
		output step,
		input  digest
	);

	modport dp (
		input  load_state,
		input  second_pass,
		input  step,
		input  round,
		output digest
	);

endinterface

`default_nettype wire

/* verilog/work_shift_in.sv */
/*
 * Host byte input. rd_strb is asynchronous and each level must be held for at
 * least four clk cycles. The first byte sent ends up in data bits 7:0.
 */
`timescale 1ns/10ps
`default_nettype none

module work_shift_in
	import miner_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       rd_strb,
	input  logic [7:0] rd_data,
	output work_t      work
);

	logic [3:0]              strb_hist;
	logic [7:0]              data_q;
	logic [work_bytes*8-1:0] stage;
	logic                    strb_edge;

	// bit 0 is the newest sample, three older equal samples filter glitches
	assign strb_edge = (strb_hist[3] == strb_hist[2]) && (strb_hist[2] == strb_hist[1])
		&& (strb_hist[1] != strb_hist[0]);

	always_ff @(posedge clk)
	begin
		if (rst)
			strb_hist <= '0;
		else
			strb_hist <= {strb_hist[2:0], rd_strb};
	end

	always_ff @(posedge clk)
	begin
		data_q <= rd_data;
		if (strb_edge)
			stage <= {data_q, stage[work_bytes*8-1:8]};
		// the miner may sample work at any time, so it sees a half-loaded unit
		// while the host is still sending
		work <= stage;
	end

endmodule

`default_nettype wire

/* verilog/result_shift_out.sv */
/*
 * Host byte output. Raising wr_start freezes the result five cycles after it
 * falls again; each filtered wr_strb edge then moves the next byte to wr_data.
 * Results change every nonce, so the host must read them out promptly.
 */
`timescale 1ns/10ps
`default_nettype none

module result_shift_out
	import miner_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_strb,
	input  logic       wr_start,
	input  word_t      hash2,
	input  word_t      nonce2,
	input  word_t      golden_nonce,
	output logic [7:0] wr_data
);

	logic [1:0]                start_q;
	logic [4:0]                arm_delay;
	logic [3:0]                strb_hist;
	logic [result_bytes*8-1:0] outbuf;
	logic                      strb_edge;
	logic                      armed;

	assign strb_edge = (strb_hist[3] == strb_hist[2]) && (strb_hist[2] == strb_hist[1])
		&& (strb_hist[1] != strb_hist[0]);

	// a one walks up the delay line once wr_start is seen low
	assign armed = arm_delay[4];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			start_q <= '0;
			arm_delay <= '0;
			strb_hist <= '0;
			outbuf <= '0;
			wr_data <= '0;
		end
		else
		begin
			start_q <= {start_q[0], wr_start};
			strb_hist <= {strb_hist[2:0], wr_strb};
			if (&start_q)
				arm_delay <= '0;
			else
				arm_delay <= {arm_delay[3:0], 1'b1};

			if (!armed)
				outbuf <= {hash2, nonce2, golden_nonce};
			else if (strb_edge)
				outbuf <= {8'h00, outbuf[result_bytes*8-1:8]};

			wr_data <= outbuf[7:0];
		end
	end

endmodule

`default_nettype wire

/* verilog/sha256_rounds.sv */
/*
 * Iterative SHA-256 compression, one round per clock. The schedule is a
 * 16-word window that shifts by one word per round. midstate, data and nonce
 * are only sampled on load_state; midstate must also hold until the first
 * digest is taken.
 */
`timescale 1ns/10ps
`default_nettype none

module sha256_rounds
	import miner_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	sha_round_if.dp     rif,
	input  hash_state_t midstate,
	input  logic [95:0] data,
	input  word_t       nonce
);

	hash_state_t st;
	hash_state_t init_value;
	hash_state_t first_digest;
	word_t       w [0:15];
	word_t       w_new;
	word_t       t1;
	word_t       t2;
	logic        step_q;

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	assign init_value = rif.second_pass ? sha_iv : midstate;

	// st[4] to st[6] are e, f and g, so the middle term is Ch(e, f, g)
	assign t1 = st[7] + big_sigma1(st[4]) + ((st[4] & st[5]) ^ (~st[4] & st[6]))
		+ round_k[rif.round] + w[0];
	assign t2 = big_sigma0(st[0]) + ((st[0] & st[1]) ^ (st[0] & st[2]) ^ (st[1] & st[2]));

	// w[0] is W(t), so W(t+16) is built from W(t+14), W(t+9), W(t+1) and W(t)
	assign w_new = small_sigma1(w[14]) + w[9] + small_sigma0(w[1]) + w[0];

	always_comb
	begin
		for (int i = 0; i < 8; i++)
			rif.digest[i] = init_value[i] + st[i];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			step_q <= 1'b0;
		else
			step_q <= rif.step;
	end

	always_ff @(posedge clk)
	begin
		if (rif.load_state)
		begin
			st <= init_value;
			if (rif.second_pass)
			begin
				for (int i = 0; i < 8; i++)
				begin
					w[i] <= first_digest[i];
					w[8 + i] <= pad_second[i];
				end
			end
			else
			begin
				w[0] <= data[31:0];
				w[1] <= data[63:32];
				w[2] <= data[95:64];
				w[3] <= nonce;
				for (int i = 0; i < 12; i++)
					w[4 + i] <= pad_first[i];
			end
		end
		else if (rif.step)
		begin
			st <= {st[6], st[5], st[4], st[3] + t1, st[2], st[1], st[0], t1 + t2};
			for (int i = 0; i < 15; i++)
				w[i] <= w[i + 1];
			w[15] <= w_new;
		end

		// the cycle right after the last round of the first pass
		if (step_q && !rif.step && !rif.second_pass)
			first_digest <= rif.digest;
	end

endmodule

`default_nettype wire

/* verilog/round_counter.sv */
/*
 * Round index of the current compression pass. clear wins over step.
 * The count wraps to zero after round 63.
 */
`timescale 1ns/10ps
`default_nettype none

module round_counter
	import miner_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       clear,
	input  logic       step,
	output logic [5:0] round,
	output logic       last
);

	always_ff @(posedge clk)
	begin
		if (rst || clear)
			round <= '0;
		else if (step)
			round <= round + 6'd1;
	end

	assign last = (round == 6'(num_rounds - 1));

endmodule

`default_nettype wire

/* verilog/miner_fsm.sv */
/*
 * Nonce sequencer. Every nonce takes 132 clocks and nonces follow back to back.
 * Work is sampled once per nonce, at its load, and the nonce keeps counting
 * across new work. Results are overwritten at the end of every nonce.
 */
`timescale 1ns/10ps
`default_nettype none

module miner_fsm
	import miner_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	sha_round_if.ctrl   rif,
	output logic        cnt_clear,
	output logic        cnt_step,
	input  logic        last,
	input  work_t       work,
	output hash_state_t midstate,
	output logic [95:0] data,
	output word_t       nonce,
	output word_t       hash2,
	output word_t       nonce2,
	output word_t       golden_nonce
);

	// idle is only seen for one cycle after reset
	typedef enum logic [2:0] {
		st_idle,
		st_load1,
		st_run1,
		st_fin1,
		st_load2,
		st_run2,
		st_capture
	} state_t;

	state_t      state;
	state_t      state_next;
	hash_state_t midstate_q;

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:    state_next = st_load1;
			st_load1:   state_next = st_run1;
			st_run1:    if (last) state_next = st_fin1;
			st_fin1:    state_next = st_load2;
			st_load2:   state_next = st_run2;
			st_run2:    if (last) state_next = st_capture;
			st_capture: state_next = st_load1;
			default:    state_next = st_idle;
		endcase
	end

	assign rif.load_state = (state == st_load1) || (state == st_load2);
	assign rif.step = (state == st_run1) || (state == st_run2);
	assign rif.second_pass = (state == st_load2) || (state == st_run2) || (state == st_capture);

	assign cnt_clear = rif.load_state;
	assign cnt_step = rif.step;

	// the datapath loads from the live work in the same cycle it is latched here
	assign midstate = (state == st_load1) ? work.midstate : midstate_q;
	assign data = work.data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			nonce <= '0;
			nonce2 <= '0;
			hash2 <= '0;
			golden_nonce <= '0;
		end
		else
		begin
			state <= state_next;
			if (state == st_capture)
			begin
				nonce2 <= nonce;
				hash2 <= rif.digest[7];
				if (rif.digest[7][31 -: golden_bits] == '0)
					golden_nonce <= nonce;
				nonce <= nonce + 32'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == st_load1)
			midstate_q <= work.midstate;
	end

endmodule

`default_nettype wire

/* verilog/miner_top.sv */
/*
 * Miner with a byte-wide host port. All logic runs on clk; the host strobes
 * and wr_start are treated as asynchronous and filtered inside.
 */
`timescale 1ns/10ps
`default_nettype none

module miner_top
	import miner_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       rd_strb,
	input  logic [7:0] rd_data,
	input  logic       wr_strb,
	input  logic       wr_start,
	output logic [7:0] wr_data
);

	work_t       work;
	hash_state_t midstate;
	logic [95:0] data;
	word_t       nonce;
	word_t       hash2;
	word_t       nonce2;
	word_t       golden_nonce;
	logic        cnt_clear;
	logic        cnt_step;
	logic        last;

	sha_round_if rif ();

	work_shift_in i_work_shift_in (
		.clk     (clk),
		.rst     (rst),
		.rd_strb (rd_strb),
		.rd_data (rd_data),
		.work    (work)
	);

	miner_fsm i_miner_fsm (
		.clk          (clk),
		.rst          (rst),
		.rif          (rif.ctrl),
		.cnt_clear    (cnt_clear),
		.cnt_step     (cnt_step),
		.last         (last),
		.work         (work),
		.midstate     (midstate),
		.data         (data),
		.nonce        (nonce),
		.hash2        (hash2),
		.nonce2       (nonce2),
		.golden_nonce (golden_nonce)
	);

	round_counter i_round_counter (
		.clk   (clk),
		.rst   (rst),
		.clear (cnt_clear),
		.step  (cnt_step),
		.round (rif.round),
		.last  (last)
	);

	sha256_rounds i_sha256_rounds (
		.clk      (clk),
		.rst      (rst),
		.rif      (rif.dp),
		.midstate (midstate),
		.data     (data),
		.nonce    (nonce)
	);

	result_shift_out i_result_shift_out (
		.clk          (clk),
		.rst          (rst),
		.wr_strb      (wr_strb),
		.wr_start     (wr_start),
		.hash2        (hash2),
		.nonce2       (nonce2),
		.golden_nonce (golden_nonce),
		.wr_data      (wr_data)
	);

endmodule

`default_nettype wire

/* test/miner_tb_sva.sv */
/*
 * Assertions bound into the miner top level. armed and strb_edge are taken
 * from the result output block.
 */
`timescale 1ns/10ps
`default_nettype none

module miner_tb_sva
	import miner_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic [5:0] round,
	input logic       load_state,
	input logic       step,
	input logic [7:0] wr_data,
	input logic       armed,
	input logic       strb_edge
);

	// a pass runs exactly from round 0 to the last round
	round_starts_at_zero: assert property (@(posedge clk) disable iff (rst)
		$rose(step) |-> round == '0)
		else $error("a compression pass did not start at round zero");

	round_ends_at_last: assert property (@(posedge clk) disable iff (rst)
		$fell(step) |-> $past(round) == 6'(num_rounds - 1))
		else $error("a compression pass did not end on the last round");

	load_then_step: assert property (@(posedge clk) disable iff (rst)
		load_state |=> step && !load_state)
		else $error("load_state was not followed by a round");

	// outbuf moves one cycle before wr_data does
	wr_data_stable: assert property (@(posedge clk) disable iff (rst)
		$changed(wr_data) |-> $past(!armed || strb_edge, 2))
		else $error("wr_data changed while the result register was frozen");

endmodule

bind miner_top miner_tb_sva i_miner_tb_sva (
	.clk        (clk),
	.rst        (rst),
	.round      (rif.round),
	.load_state (rif.load_state),
	.step       (rif.step),
	.wr_data    (wr_data),
	.armed      (i_result_shift_out.armed),
	.strb_edge  (i_result_shift_out.strb_edge)
);

`default_nettype wire

/* test/miner_tb.sv */
/*
 * Testbench of the miner. Work units come from an LFSR and results are read
 * back over the byte port and checked against a SHA-256 model. A golden nonce
 * found while a unit was half loaded can only be checked for being nonzero.
 */
`timescale 1ns/10ps
`default_nettype none

module miner_tb
	import miner_pkg::*;
();

	localparam int num_units = 40;
	localparam int golden_polls = 128;
	localparam int cycle_limit = num_units * (44 * 12 + 3 * 300 + 12 * 16)
		+ golden_polls * 2200 + 5000;

	localparam logic [255:0] model_iv = {
		32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
		32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
	};

	localparam logic [31:0] k_tab [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	logic        clk;
	logic        rst;
	logic        rd_strb;
	logic [7:0]  rd_data;
	logic        wr_strb;
	logic        wr_start;
	logic [7:0]  wr_data;
	logic [31:0] lfsr;
	logic [31:0] unit_first;
	logic        golden_seen;
	int          errors;
	int          cycles;

	miner_top i_miner_top (
		.clk      (clk),
		.rst      (rst),
		.rd_strb  (rd_strb),
		.rd_data  (rd_data),
		.wr_strb  (wr_strb),
		.wr_start (wr_start),
		.wr_data  (wr_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] ror(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// one SHA-256 compression, word i of state and block sits at bits 32i+31:32i
	function automatic logic [255:0] compress(input logic [255:0] h, input logic [511:0] blk);
		logic [31:0]  w [0:63];
		logic [31:0]  v [0:7];
		logic [31:0]  t1;
		logic [31:0]  t2;
		logic [255:0] res;
		for (int i = 0; i < 16; i++)
			w[i] = blk[32*i +: 32];
		for (int i = 16; i < 64; i++)
			w[i] = (ror(w[i-2], 17) ^ ror(w[i-2], 19) ^ (w[i-2] >> 10)) + w[i-7]
				+ (ror(w[i-15], 7) ^ ror(w[i-15], 18) ^ (w[i-15] >> 3)) + w[i-16];
		for (int j = 0; j < 8; j++)
			v[j] = h[32*j +: 32];
		for (int i = 0; i < 64; i++)
		begin
			t1 = v[7] + (ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25))
				+ ((v[4] & v[5]) ^ (~v[4] & v[6])) + k_tab[i] + w[i];
			t2 = (ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22))
				+ ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int j = 7; j > 0; j--)
				v[j] = v[j-1];
			v[4] = v[4] + t1;
			v[0] = t1 + t2;
		end
		for (int j = 0; j < 8; j++)
			res[32*j +: 32] = h[32*j +: 32] + v[j];
		return res;
	endfunction

	// last word of the double hash of one nonce under one work unit
	function automatic logic [31:0] double_hash(input logic [351:0] wk, input logic [31:0] n);
		logic [255:0] d1;
		logic [255:0] d2;
		d1 = compress(wk[351:96], {32'd640, 320'd0, 32'h80000000, n, wk[95:0]});
		d2 = compress(model_iv, {32'd256, 192'd0, 32'h80000000, d1});
		return d2[255:224];
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			b = {lfsr[0], b[7:1]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act)
		else
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// byte j of the unit lands in work bits 8j+7:8j
	task automatic send_work(input logic [351:0] wk);
		for (int j = 0; j < work_bytes; j++)
		begin
			rd_data = wk[8*j +: 8];
			rd_strb = ~rd_strb;
			wait_cycles(6);
		end
	endtask

	task automatic read_result(output logic [95:0] r);
		wr_start = 1'b1;
		wait_cycles(3);
		wr_start = 1'b0;
		wait_cycles(8);
		for (int k = 0; k < result_bytes; k++)
		begin
			r[8*k +: 8] = wr_data;
			wr_strb = ~wr_strb;
			wait_cycles(8);
		end
	endtask

	task automatic check_result(input logic [95:0] r, input logic [351:0] wk);
		logic [31:0] g;
		logic [31:0] h;
		g = r[31:0];
		check_word("hash2", double_hash(wk, r[63:32]), r[95:64]);
		if (g != 0 && g >= unit_first)
		begin
			h = double_hash(wk, g);
			assert (h[31 -: golden_bits] == '0)
			else
			begin
				$display("CHECK FAILED golden_nonce expected top %0d bits zero actual %h",
					golden_bits, h);
				errors++;
			end
			golden_seen = 1'b1;
		end
	endtask

	initial
	begin
		logic [351:0] wk;
		logic [95:0]  r1;
		logic [95:0]  r2;
		errors = 0;
		cycles = 0;
		lfsr = 32'hedae;
		golden_seen = 1'b0;
		unit_first = '0;
		rst = 1'b1;
		rd_strb = 1'b0;
		rd_data = '0;
		wr_strb = 1'b0;
		wr_start = 1'b0;
		wait_cycles(5);
		rst = 1'b0;
		wait_cycles(1);
		check_word("reset_wr_data", 32'h0, {24'h0, wr_data});

		for (int u = 0; u < num_units; u++)
		begin
			for (int j = 0; j < work_bytes; j++)
				rand_byte(wk[8*j +: 8]);
			send_work(wk);
			wait_cycles(300);
			read_result(r1);
			unit_first = r1[63:32];
			check_result(r1, wk);
			wait_cycles(300);
			read_result(r2);
			check_result(r2, wk);
			assert (r2[63:32] > r1[63:32])
			else
			begin
				$display("CHECK FAILED nonce2_advance expected above %h actual %h",
					r1[63:32], r2[63:32]);
				errors++;
			end
		end

		// keep mining the last unit until a golden nonce turns up
		for (int p = 0; p < golden_polls && !golden_seen; p++)
		begin
			wait_cycles(2000);
			read_result(r1);
			check_result(r1, wk);
		end
		assert (golden_seen)
		else
		begin
			$display("no golden_nonce of a fully loaded work unit was reported during the run");
			errors++;
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* miner.f */
verilog/miner_pkg.sv
verilog/sha_round_if.sv
verilog/work_shift_in.sv
verilog/result_shift_out.sv
verilog/sha256_rounds.sv
verilog/round_counter.sv
verilog/miner_fsm.sv
verilog/miner_top.sv
test/miner_tb_sva.sv
test/miner_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = miner_tb
FILELIST = miner.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
